/* all.f */
+incdir+hw
hw/dnn_data_pkg.sv
hw/dnn_ctrl_pkg.sv
hw/mac_issue_ctrl.sv
hw/dot_product_pipe.sv
hw/result_store.sv
hw/block_reader.sv
hw/dnn_accel_top.sv
testbench/dnn_accel_props.sv
testbench/tb_dnn_accel.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dnn_accel
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(filter-out +%,$(shell cat $(FILELIST)))
HDRS = $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message appears in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_dnn_accel.sv */
// Testbench for the dot-product engine: random batches checked against a queue-based model
`include "dnn_accel_defines.svh"

module tb_dnn_accel
    import dnn_data_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Wait limits in clock cycles
    localparam int FILL_TIMEOUT  = 1000;
    localparam int READY_TIMEOUT = 20;
    localparam int START_TIMEOUT = 10;

    logic          clk;
    logic          rst_n;
    logic          mac_en;
    dot_operands_t mac_operands;
    logic          rdy_mac;
    logic          block_read;
    logic          rdy_block_read;
    logic          mem_valid;
    dot_result_t   mem_data;

    logic [31:0]   rng_state;
    dot_result_t   model_q[$];
    int unsigned   err_cnt;
    int unsigned   timeout_cnt;
    int unsigned   prop_fails;

    dnn_accel_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .mac_en         (mac_en),
        .mac_operands   (mac_operands),
        .rdy_mac        (rdy_mac),
        .block_read     (block_read),
        .rdy_block_read (rdy_block_read),
        .mem_valid      (mem_valid),
        .mem_data       (mem_data)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==============================
    // Stimulus and model
    // ==============================

    // xorshift32 step, state kept across calls
    function automatic logic [31:0] next_rand();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    // Kind 1 gives all-ones lanes, kind 2 all zeros, anything else random
    function automatic dot_operands_t make_vector(input int kind);
        dot_operands_t v;
        logic [31:0]   r;
        for (int i = 0; i < `DNN_LANES; i++) begin
            r = next_rand();
            case (kind)
                1: begin
                    v.vec_a[i] = '1;
                    v.vec_b[i] = '1;
                end
                2: begin
                    v.vec_a[i] = '0;
                    v.vec_b[i] = '0;
                end
                default: begin
                    v.vec_a[i] = r[31:16];
                    v.vec_b[i] = r[15:0];
                end
            endcase
        end
        return v;
    endfunction

    // Unsigned sum of the lane products, done in 64 bits then narrowed
    function automatic dot_result_t expected_dot(input dot_operands_t v);
        logic [63:0] acc;
        acc = 64'd0;
        for (int i = 0; i < `DNN_LANES; i++) begin
            acc = acc + 64'(v.vec_a[i]) * 64'(v.vec_b[i]);
        end
        return dot_result_t'(acc);
    endfunction

    // ==============================
    // Batch tasks
    // ==============================

    // Offers vectors with random gaps until 64 are accepted
    task automatic fill_batch(input bit special);
        int          accepts;
        int          cycles;
        int          offered;
        int          kind;
        int          since;
        logic [31:0] r;
        accepts = 0;
        cycles  = 0;
        offered = 0;
        while (accepts < `DNN_DEPTH && cycles < FILL_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (rdy_block_read !== 1'b0 || mem_valid !== 1'b0) begin
                err_cnt++;
                $display("Error at %0t ns: read side active while filling", $time);
            end
            if (mac_en && rdy_mac) begin
                model_q.push_back(expected_dot(mac_operands));
                accepts++;
            end
            // Early block_read, must be ignored
            block_read <= (cycles == 5);
            r = next_rand();
            if (r[1:0] == 2'b00) begin
                mac_en <= 1'b0;
            end else begin
                if (special && offered % 5 == 0) begin
                    kind = 1;
                end else if (special && offered % 5 == 1) begin
                    kind = 2;
                end else begin
                    kind = 0;
                end
                mac_en       <= 1'b1;
                mac_operands <= make_vector(kind);
                offered++;
            end
        end
        if (accepts < `DNN_DEPTH) begin
            timeout_cnt++;
            $display("Timeout: the batch did not reach 64 accepted vectors");
        end
        // Keep offering while rdy_mac is low until the store reports full
        since = 0;
        while (rdy_block_read !== 1'b1 && since < READY_TIMEOUT) begin
            @(posedge clk);
            since++;
            if (rdy_mac !== 1'b0) begin
                err_cnt++;
                $display("Error at %0t ns: rdy_mac high after 64 accepts", $time);
            end
            mac_en       <= 1'b1;
            mac_operands <= make_vector(0);
        end
        mac_en <= 1'b0;
        if (rdy_block_read !== 1'b1) begin
            timeout_cnt++;
            $display("Timeout: rdy_block_read never rose after the batch was accepted");
        end else if (since > 6) begin
            // Last write lands on the fifth edge, seen at the sixth
            err_cnt++;
            $display("Error at %0t ns: rdy_block_read rose %0d cycles after last accept",
                     $time, since);
        end
    endtask

    // Starts a block read and checks the 64-result stream in order
    task automatic read_batch();
        int          wait_cyc;
        dot_result_t exp_val;
        block_read <= 1'b1;
        // Start edge
        @(posedge clk);
        block_read <= 1'b0;
        wait_cyc = 0;
        while (mem_valid !== 1'b1 && wait_cyc < START_TIMEOUT) begin
            @(posedge clk);
            wait_cyc++;
            if (rdy_block_read !== 1'b0) begin
                err_cnt++;
                $display("Error at %0t ns: rdy_block_read high during a read", $time);
            end
        end
        if (mem_valid !== 1'b1) begin
            timeout_cnt++;
            $display("Timeout: mem_valid never rose after the block read");
        end else begin
            if (wait_cyc != 3) begin
                err_cnt++;
                $display("Error at %0t ns: first mem_valid %0d cycles after start",
                         $time, wait_cyc);
            end
            for (int n = 0; n < `DNN_DEPTH; n++) begin
                if (n > 0) begin
                    @(posedge clk);
                end
                if (mem_valid !== 1'b1) begin
                    err_cnt++;
                    $display("Error at %0t ns: mem_valid low at result %0d", $time, n);
                end else if (model_q.size() == 0) begin
                    err_cnt++;
                    $display("Error at %0t ns: result %0d with empty model", $time, n);
                end else begin
                    exp_val = model_q.pop_front();
                    if (mem_data !== exp_val) begin
                        err_cnt++;
                        $display("Error at %0t ns: result %0d is %h, expected %h",
                                 $time, n, mem_data, exp_val);
                    end
                end
            end
            @(posedge clk);
            if (mem_valid !== 1'b0) begin
                err_cnt++;
                $display("Error at %0t ns: mem_valid longer than 64 cycles", $time);
            end
        end
        // Credits come back on batch_done
        wait_cyc = 0;
        while (rdy_mac !== 1'b1 && wait_cyc < READY_TIMEOUT) begin
            @(posedge clk);
            wait_cyc++;
        end
        if (rdy_mac !== 1'b1) begin
            timeout_cnt++;
            $display("Timeout: rdy_mac did not return after the block read");
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        rng_state    = 32'h753d;
        err_cnt      = 0;
        timeout_cnt  = 0;
        rst_n        = 1'b0;
        mac_en       = 1'b0;
        block_read   = 1'b0;
        mac_operands = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (rdy_mac !== 1'b1 || rdy_block_read !== 1'b0 || mem_valid !== 1'b0) begin
            err_cnt++;
            $display("Error at %0t ns: wrong ready or valid levels after reset", $time);
        end
        // Random batch, then one with corner vectors
        fill_batch(1'b0);
        read_batch();
        fill_batch(1'b1);
        read_batch();
        if (model_q.size() != 0) begin
            err_cnt++;
            $display("Error at %0t ns: %0d model results never read", $time, model_q.size());
        end
        repeat (4) @(posedge clk);
        prop_fails = dut.u_props.fail_cnt;
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 err_cnt, timeout_cnt, prop_fails);
        if (err_cnt == 0 && timeout_cnt == 0 && prop_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* testbench/dnn_accel_props.sv */
// Handshake and batch-state assertions, attached to the engine top level by bind
`include "dnn_accel_defines.svh"

module dnn_accel_props
    import dnn_ctrl_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         rdy_mac,
    input logic         rdy_block_read,
    input logic         mem_valid,
    input logic         result_valid,
    input logic         store_full,
    input batch_state_t state
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertion count, read by the testbench at the end
    int unsigned fail_cnt = 0;

    // ==============================
    // Properties
    // ==============================

    // Filling and draining never overlap
    ready_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(rdy_mac && rdy_block_read))
    else begin
        $error("rdy_mac and rdy_block_read high together");
        fail_cnt++;
    end

    // Output stream only while reading
    valid_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid |-> (state == batch_reading))
    else begin
        $error("mem_valid outside the reading state");
        fail_cnt++;
    end

    // No write into a full store
    no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> !store_full)
    else begin
        $error("result_valid while the store is full");
        fail_cnt++;
    end

endmodule

bind dnn_accel_top dnn_accel_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .rdy_mac        (rdy_mac),
    .rdy_block_read (rdy_block_read),
    .mem_valid      (mem_valid),
    .result_valid   (result_valid),
    .store_full     (store_full),
    .state          (u_reader.state)
);

/* hw/dnn_accel_top.sv */
// Top level of the dot-product engine: issue control, pipeline, result store and block reader
module dnn_accel_top
    import dnn_data_pkg::*;
    import dnn_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    // Operand side
    input  logic          mac_en,
    input  dot_operands_t mac_operands,
    output logic          rdy_mac,
    // Block read side
    input  logic          block_read,
    output logic          rdy_block_read,
    output logic          mem_valid,
    output dot_result_t   mem_data
);

    // ==============================
    // Internal connections
    // ==============================

    // Issue control to pipeline
    logic          issue_valid;
    dot_operands_t issue_operands;

    // Pipeline to store
    logic          result_valid;
    dot_result_t   result_data;

    // Store and reader
    logic          store_full;
    logic          store_clear;
    logic          read_en;
    store_addr_t   read_addr;
    dot_result_t   read_data;

    // Reader back to issue control
    logic          batch_done;

    mac_issue_ctrl u_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .mac_en         (mac_en),
        .mac_operands   (mac_operands),
        .batch_done     (batch_done),
        .rdy_mac        (rdy_mac),
        .issue_valid    (issue_valid),
        .issue_operands (issue_operands)
    );

    dot_product_pipe u_pipe (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue_operands (issue_operands),
        .result_valid   (result_valid),
        .result_data    (result_data)
    );

    result_store u_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .result_valid (result_valid),
        .result_data  (result_data),
        .store_clear  (store_clear),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .store_full   (store_full),
        .read_data    (read_data)
    );

    block_reader u_reader (
        .clk            (clk),
        .rst_n          (rst_n),
        .store_full     (store_full),
        .block_read     (block_read),
        .read_data      (read_data),
        .rdy_block_read (rdy_block_read),
        .read_en        (read_en),
        .read_addr      (read_addr),
        .store_clear    (store_clear),
        .batch_done     (batch_done),
        .mem_valid      (mem_valid),
        .mem_data       (mem_data)
    );

endmodule

/* hw/block_reader.sv */
// Block read sequencer: walks the full result store once and streams results out in order
`include "dnn_accel_defines.svh"

module block_reader
    import dnn_data_pkg::*;
    import dnn_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        store_full,
    input  logic        block_read,
    input  dot_result_t read_data,
    output logic        rdy_block_read,
    output logic        read_en,
    output store_addr_t read_addr,
    output logic        store_clear,
    output logic        batch_done,
    output logic        mem_valid,
    output dot_result_t mem_data
);

    batch_state_t state;
    batch_state_t state_nxt;

    logic        start;
    logic        last_read;
    logic        rd_active;
    store_addr_t rd_addr;
    // Delay taps matching the store read register
    logic        rd_valid_q;
    logic        rd_last_q;

    // ==============================
    // Batch FSM
    // ==============================

    // Ready once the store is full and only until a read starts
    assign rdy_block_read = store_full && (state != batch_reading);
    assign start          = block_read && rdy_block_read;

    always_comb begin
        state_nxt = state;
        case (state)
            batch_filling: begin
                if (start) begin
                    state_nxt = batch_reading;
                end else if (store_full) begin
                    state_nxt = batch_full;
                end
            end
            batch_full: begin
                if (start) begin
                    state_nxt = batch_reading;
                end
            end
            // Hold until the last result has left the output register
            batch_reading: begin
                if (batch_done) begin
                    state_nxt = batch_idle;
                end
            end
            batch_idle: begin
                if (!store_full) begin
                    state_nxt = batch_filling;
                end
            end
            default: state_nxt = batch_filling;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= batch_filling;
        end else begin
            state <= state_nxt;
        end
    end

    // ==============================
    // Address sequencer
    // ==============================

    assign last_read   = rd_active && (rd_addr == store_addr_t'(`DNN_DEPTH - 1));
    assign read_en     = rd_active;
    assign read_addr   = rd_addr;
    // Store may refill as soon as the final address is issued
    assign store_clear = last_read;

    // 64 back-to-back reads, address wraps to zero after the last one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            rd_addr   <= '0;
        end else if (start) begin
            rd_active <= 1'b1;
            rd_addr   <= '0;
        end else if (rd_active) begin
            rd_addr <= rd_addr + store_addr_t'(1);
            if (last_read) begin
                rd_active <= 1'b0;
            end
        end
    end

    // ==============================
    // Output stage
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
            rd_last_q  <= 1'b0;
            mem_valid  <= 1'b0;
            batch_done <= 1'b0;
        end else begin
            rd_valid_q <= rd_active;
            rd_last_q  <= last_read;
            mem_valid  <= rd_valid_q;
            batch_done <= rd_last_q;   // same cycle as the final mem_valid
        end
    end

    // Output data register, paired with mem_valid
    always_ff @(posedge clk) begin
        if (rd_valid_q) begin
            mem_data <= read_data;
        end
    end

endmodule

/* hw/result_store.sv */
// Internal 64-entry result memory, filled in order by the pipeline and drained by the block reader
`include "dnn_accel_defines.svh"

module result_store
    import dnn_data_pkg::*;
    import dnn_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        result_valid,
    input  dot_result_t result_data,
    input  logic        store_clear,
    input  logic        read_en,
    input  store_addr_t read_addr,
    output logic        store_full,
    output dot_result_t read_data
);

    dot_result_t mem [`DNN_DEPTH];
    store_addr_t wr_ptr;

    // ==============================
    // Write side
    // ==============================

    // Results arrive in acceptance order
    always_ff @(posedge clk) begin
        if (result_valid) begin
            mem[wr_ptr] <= result_data;
        end
    end

    // Pointer wraps back to zero on the last slot and raises full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            store_full <= 1'b0;
        end else if (store_clear) begin
            wr_ptr     <= '0;
            store_full <= 1'b0;
        end else if (result_valid) begin
            wr_ptr <= wr_ptr + store_addr_t'(1);
            if (wr_ptr == store_addr_t'(`DNN_DEPTH - 1)) begin
                store_full <= 1'b1;
            end
        end
    end

    // ==============================
    // Read side
    // ==============================

    // Registered read, data valid one cycle after read_en
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

/* hw/dot_product_pipe.sv */
// Four-lane dot-product pipeline: two-stage multiply followed by a two-level adder tree
`include "dnn_accel_defines.svh"

module dot_product_pipe
    import dnn_data_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          issue_valid,
    input  dot_operands_t issue_operands,
    output logic          result_valid,
    output dot_result_t   result_data
);

    // Multiplier split on the B operand
    localparam int HALF_W = `DNN_OPERAND_W / 2;
    localparam int PP_W   = `DNN_OPERAND_W + HALF_W;
    // Pairwise sums carry one growth bit
    localparam int PSUM_W = `DNN_PROD_W + 1;
    localparam int RES_W  = `DNN_RESULT_W;

    // Valid bit per register stage, bit 0 is the first stage
    logic [`DNN_PIPE_LAT-1:0] valid_sr;

    logic [`DNN_LANES-1:0][PP_W-1:0] pp_lo;
    logic [`DNN_LANES-1:0][PP_W-1:0] pp_hi;
    product_t [`DNN_LANES-1:0]       prod;
    logic [PSUM_W-1:0]               psum_01;
    logic [PSUM_W-1:0]               psum_23;
    dot_result_t                     sum_q;

    // ==============================
    // Valid tracking
    // ==============================

    // No stall, so a plain shift register follows the data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[`DNN_PIPE_LAT-2:0], issue_valid};
        end
    end

    // ==============================
    // Multiply, two cycles
    // ==============================

    // Stage 1: A times low and high byte of B per lane
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            for (int i = 0; i < `DNN_LANES; i++) begin
                pp_lo[i] <= PP_W'(issue_operands.vec_a[i])
                          * PP_W'(issue_operands.vec_b[i][HALF_W-1:0]);
                pp_hi[i] <= PP_W'(issue_operands.vec_a[i])
                          * PP_W'(issue_operands.vec_b[i][`DNN_OPERAND_W-1:HALF_W]);
            end
        end
    end

    // Stage 2: shift the high partial and combine
    // The true product fits in 32 bits so the carry out is always zero
    always_ff @(posedge clk) begin
        if (valid_sr[0]) begin
            for (int i = 0; i < `DNN_LANES; i++) begin
                prod[i] <= {pp_hi[i], {HALF_W{1'b0}}} + `DNN_PROD_W'(pp_lo[i]);
            end
        end
    end

    // ==============================
    // Adder tree
    // ==============================

    // Level 1: lanes 0+1 and 2+3
    always_ff @(posedge clk) begin
        if (valid_sr[1]) begin
            psum_01 <= PSUM_W'(prod[0]) + PSUM_W'(prod[1]);
            psum_23 <= PSUM_W'(prod[2]) + PSUM_W'(prod[3]);
        end
    end

    // Level 2: final 34-bit sum
    always_ff @(posedge clk) begin
        if (valid_sr[2]) begin
            sum_q <= RES_W'(psum_01) + RES_W'(psum_23);
        end
    end

    // Result strobe lands DNN_PIPE_LAT cycles after issue
    assign result_valid = valid_sr[`DNN_PIPE_LAT-1];
    assign result_data  = sum_q;

endmodule

/* hw/mac_issue_ctrl.sv */
// Operand input stage: accepts vectors while credits remain and issues them to the pipeline
`include "dnn_accel_defines.svh"

module mac_issue_ctrl
    import dnn_data_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          mac_en,
    input  dot_operands_t mac_operands,
    input  logic          batch_done,
    output logic          rdy_mac,
    output logic          issue_valid,
    output dot_operands_t issue_operands
);

    // One extra bit so the count can reach the full depth
    localparam int CNT_W = `DNN_ADDR_W + 1;

    logic [CNT_W-1:0] issue_cnt;
    logic             accept;

    // ==============================
    // Credits
    // ==============================

    // Each accept uses one store slot, so no slack is needed downstream
    assign rdy_mac = (issue_cnt < CNT_W'(`DNN_DEPTH));
    assign accept  = mac_en && rdy_mac;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_cnt   <= '0;
            issue_valid <= 1'b0;
        end else begin
            // Pulse lines up with the registered operands
            issue_valid <= accept;
            // Batch drained, all credits come back
            if (batch_done) begin
                issue_cnt <= '0;
            end else if (accept) begin
                issue_cnt <= issue_cnt + CNT_W'(1);
            end
        end
    end

    // ==============================
    // Input register
    // ==============================

    // Holds the last accepted vector, only read while issue_valid is high
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_operands <= mac_operands;
        end
    end

endmodule

/* hw/dnn_ctrl_pkg.sv */
// Batch control types shared by the result store, the block reader and the checks
`include "dnn_accel_defines.svh"

package dnn_ctrl_pkg;

    // Address into the 64-entry result store
    typedef logic [`DNN_ADDR_W-1:0] store_addr_t;

    // ==============================
    // Batch sequence
    // ==============================
    // Filling until the store reports full, full until a block read
    // starts, reading until the last result leaves, then idle for one
    // cycle while the store flag drops
    typedef enum logic [1:0] {
        batch_filling = 2'd0,
        batch_full    = 2'd1,
        batch_reading = 2'd2,
        batch_idle    = 2'd3
    } batch_state_t;

endpackage

/* hw/dnn_data_pkg.sv */
// Operand and result types shared by every block on the dot-product data path
`include "dnn_accel_defines.svh"

package dnn_data_pkg;

    // ==============================
    // Operands
    // ==============================

    // Single unsigned element of either vector
    typedef logic [`DNN_OPERAND_W-1:0] operand_t;

    // One accepted vector: lane i pairs vec_a[i] with vec_b[i]
    // 2 x 4 x 16 = 128 bits
    typedef struct packed {
        operand_t [`DNN_LANES-1:0] vec_a;
        operand_t [`DNN_LANES-1:0] vec_b;
    } dot_operands_t;

    // ==============================
    // Results
    // ==============================

    // Product of one lane
    typedef logic [`DNN_PROD_W-1:0] product_t;

    // Unsigned sum of all lane products, never overflows
    typedef logic [`DNN_RESULT_W-1:0] dot_result_t;

endpackage

/* hw/dnn_accel_defines.svh */
// Sizing macros for the dot-product engine, included by packages and modules that need them
`ifndef DNN_ACCEL_DEFINES_SVH
`define DNN_ACCEL_DEFINES_SVH

// ==============================
// Data path widths
// ==============================

// One unsigned operand element
`define DNN_OPERAND_W 16

// Element pairs per operand vector
`define DNN_LANES 4

// Full product of two operand elements
`define DNN_PROD_W 32

// Sum of four products needs two growth bits
`define DNN_RESULT_W 34

// ==============================
// Result store and timing
// ==============================

// Results per batch, equal to the issue credits
`define DNN_DEPTH 64
`define DNN_ADDR_W 6

// Cycles from issue_valid to result_valid
`define DNN_PIPE_LAT 4

`endif
